// ==== all.f ====
design/backendPkg.sv
design/archRegFile.sv
design/dispatch.sv
design/issueQueue.sv
design/divider.sv
design/execPort.sv
design/reorderBuffer.sv
design/backendCore.sv
bench/clockGen.sv
bench/backendAssertions.sv
bench/backendTb.sv

// ==== Bender.yml ====
package:
  name: backend_core

sources:
  - files:
      - design/backendPkg.sv
      - design/archRegFile.sv
      - design/dispatch.sv
      - design/issueQueue.sv
      - design/divider.sv
      - design/execPort.sv
      - design/reorderBuffer.sv
      - design/backendCore.sv
  - target: test
    files:
      - bench/clockGen.sv
      - bench/backendAssertions.sv
      - bench/backendTb.sv

// ==== bench/backendTb.sv ====
`timescale 1ns/1ps

module backendTb;

import backendPkg::*;

localparam int periodNs = 100;
localparam int stimDelay = 5;
localparam int robDepth = 8;
localparam int iqDepth = 4;

// instructions sent by each test, they size the watchdog.
localparam int aluCount = 23;
localparam int chainCount = 8;
localparam int divideCount = 12;
localparam int burstCount = 20;
localparam int randomCount = 200;
localparam int instrBudget = 1 + aluCount + chainCount + divideCount + burstCount + randomCount;
localparam longint watchdogNs = (longint'(instrBudget) * 200 + 2000) * periodNs;

logic clk;
logic rstN;
instr_t instr;
logic stall;
commit_t commit;

word_t modelRegs[32];
commit_t expQ[$];
commit_t expCommit;
sqN_t expSqN;
logic [31:0] rngState;
logic sawStall;
string curTest;
int checkCount;
int errorCount;
int testErrors;
int testCount;
int failedTests;

clockGen #(.periodNs(periodNs), .resetCycles(4)) clkGen
(
    .clk(clk),
    .rstN(rstN)
);

backendCore #(.robDepth(robDepth), .iqDepth(iqDepth)) dut_i
(
    .clk(clk),
    .rstN(rstN),
    .instr(instr),
    .stall(stall),
    .commit(commit)
);

function automatic logic [31:0] nextRandom();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
endfunction

function automatic word_t computeExpected(aluOp_t op, word_t a, word_t b);
    logic [63:0] extended;
    extended = {{32{a[31]}}, a} >> b[4:0];
    case (op)
        opAdd: return a + b;
        opSub: return a + ~b + 1;
        opAnd: return a & b;
        opOr: return a | b;
        opXor: return a ^ b;
        opSll: return a << b[4:0];
        opSrl: return a >> b[4:0];
        opSra: return extended[31:0];
        opSlt: return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
        opSltu: return {31'b0, a < b};
        opDivu: return (b == 0) ? 32'hffff_ffff : a / b;
        opRemu: return (b == 0) ? a : a % b;
        default: return '0;
    endcase
endfunction

task automatic compareValues(string what, logic [31:0] expected, logic [31:0] actual);
    checkCount++;
    if (expected !== actual) begin
        $display("Error %s %s: expected %h, actual %h", curTest, what, expected, actual);
        errorCount++;
        testErrors++;
    end
endtask

// the model runs in program order, at the moment of acceptance.
task automatic predictCommit(instr_t i);
    word_t a;
    word_t b;
    word_t v;
    a = modelRegs[i.rs1];
    b = i.useImm ? i.imm : modelRegs[i.rs2];
    v = computeExpected(i.op, a, b);
    expQ.push_back('{valid: 1'b1, sqN: expSqN, rd: i.rd, value: v});
    expSqN = expSqN + 1'b1;
    if (i.rd != 0)
        modelRegs[i.rd] = v;
endtask

task automatic sendInstr(aluOp_t op, regIdx_t rd, regIdx_t rs1, regIdx_t rs2,
                         word_t imm, logic useImm);
    instr_t i;
    logic wasStalled;
    i = '{valid: 1'b1, op: op, rd: rd, rs1: rs1, rs2: useImm ? 5'd0 : rs2,
          imm: imm, useImm: useImm};
    instr = i;
    do begin
        @(negedge clk);
        wasStalled = stall; // stable until the next edge.
        if (wasStalled)
            sawStall = 1'b1;
        @(posedge clk);
        #stimDelay;
    end while (wasStalled);
    instr = '0;
    predictCommit(i);
endtask

task automatic startTest(string name);
    curTest = name;
    testErrors = 0;
endtask

task automatic finishTest();
    while (expQ.size() != 0)
        @(posedge clk);
    @(posedge clk);
    #stimDelay;
    testCount++;
    if (testErrors != 0)
        failedTests++;
    $display("%s: %s, %0d errors", curTest, (testErrors == 0) ? "passed" : "failed",
             testErrors);
endtask

task automatic checkIdleAfterReset();
    startTest("idle after reset");
    repeat (4) begin
        @(negedge clk);
        compareValues("stall", 0, stall);
        compareValues("commit valid", 0, commit.valid);
    end
    @(posedge clk);
    #stimDelay;
    sendInstr(opAdd, 5'd3, 5'd1, 5'd2, '0, 1'b0);
    finishTest();
endtask

task automatic exerciseAluOps();
    startTest("alu operations");
    sendInstr(opAdd, 5'd1, 5'd0, 5'd0, 32'h8000_00f3, 1'b1);
    sendInstr(opAdd, 5'd2, 5'd0, 5'd0, 32'd7, 1'b1);
    sendInstr(opAdd, 5'd3, 5'd0, 5'd0, 32'hffff_fff0, 1'b1);
    for (int k = 0; k < 10; k++) begin
        sendInstr(aluOp_t'(k), regIdx_t'(4 + k), 5'd1, 5'd2, '0, 1'b0);
        sendInstr(aluOp_t'(k), regIdx_t'(16 + k), 5'd3, 5'd0, 32'h0000_0013, 1'b1);
    end
    finishTest();
endtask

task automatic followDependentChain();
    startTest("dependent chain");
    sendInstr(opAdd, 5'd20, 5'd0, 5'd0, 32'd5, 1'b1);
    sendInstr(opAdd, 5'd20, 5'd20, 5'd0, 32'd3, 1'b1);
    sendInstr(opSll, 5'd20, 5'd20, 5'd0, 32'd2, 1'b1);
    sendInstr(opSub, 5'd21, 5'd20, 5'd1, '0, 1'b0);
    sendInstr(opXor, 5'd22, 5'd21, 5'd20, '0, 1'b0);
    sendInstr(opAdd, 5'd23, 5'd22, 5'd22, '0, 1'b0);
    sendInstr(opSra, 5'd24, 5'd23, 5'd0, 32'd4, 1'b1);
    sendInstr(opSltu, 5'd25, 5'd24, 5'd23, '0, 1'b0);
    finishTest();
endtask

task automatic orderDivides();
    startTest("divides in order");
    sendInstr(opAdd, 5'd8, 5'd0, 5'd0, 32'd100, 1'b1);
    sendInstr(opAdd, 5'd9, 5'd0, 5'd0, 32'd7, 1'b1);
    sendInstr(opDivu, 5'd10, 5'd8, 5'd9, '0, 1'b0);
    sendInstr(opRemu, 5'd11, 5'd8, 5'd9, '0, 1'b0);
    sendInstr(opAdd, 5'd12, 5'd10, 5'd11, '0, 1'b0);
    sendInstr(opAdd, 5'd13, 5'd8, 5'd0, 32'd1, 1'b1); // independent, still after.
    sendInstr(opDivu, 5'd14, 5'd8, 5'd0, '0, 1'b0);
    sendInstr(opRemu, 5'd15, 5'd8, 5'd0, '0, 1'b0);
    sendInstr(opAdd, 5'd16, 5'd0, 5'd0, 32'hffff_fffe, 1'b1);
    sendInstr(opDivu, 5'd17, 5'd16, 5'd0, 32'd3, 1'b1);
    sendInstr(opRemu, 5'd18, 5'd16, 5'd9, '0, 1'b0);
    sendInstr(opOr, 5'd19, 5'd17, 5'd0, '0, 1'b0);
    finishTest();
endtask

task automatic burstUntilStall();
    startTest("divide burst");
    sawStall = 1'b0;
    for (int k = 0; k < burstCount / 2; k++) begin
        sendInstr(opDivu, 5'd26, 5'd16, 5'd9, '0, 1'b0);
        sendInstr(opAdd, 5'd27, 5'd26, 5'd0, word_t'(k), 1'b1);
    end
    compareValues("stall seen", 1, sawStall);
    finishTest();
endtask

task automatic playRandomProgram();
    logic [31:0] r;
    word_t imm;
    startTest("random program");
    for (int k = 0; k < randomCount; k++) begin
        r = nextRandom();
        imm = nextRandom();
        if (r[17])
            imm = imm & 32'h1f; // small shifts and divisors.
        sendInstr(aluOp_t'(r[3:0] % 12), {1'b0, r[7:4]}, {1'b0, r[11:8]},
                  {1'b0, r[15:12]}, imm, r[16]);
    end
    finishTest();
endtask

always @(negedge clk) begin
    if (rstN && commit.valid) begin
        if (expQ.size() == 0) begin
            $display("Unexpected commit during %s, no instruction was outstanding", curTest);
            errorCount++;
            testErrors++;
        end else begin
            expCommit = expQ.pop_front();
            compareValues("commit sqN", expCommit.sqN, commit.sqN);
            compareValues("commit rd", expCommit.rd, commit.rd);
            compareValues("commit value", expCommit.value, commit.value);
        end
    end
end

initial begin
    #(watchdogNs);
    $display("Timeout after %0d ns, the DUT stopped accepting or committing", watchdogNs);
    $display("CHECKS FAILED");
    $finish;
end

initial begin
    instr = '0;
    for (int i = 0; i < 32; i++)
        modelRegs[i] = '0;
    expSqN = '0;
    rngState = 32'hbf74_6514;
    sawStall = 1'b0;
    curTest = "reset";
    checkCount = 0;
    errorCount = 0;
    testErrors = 0;
    testCount = 0;
    failedTests = 0;
    @(posedge rstN);
    @(posedge clk);
    #stimDelay;
    checkIdleAfterReset();
    exerciseAluOps();
    followDependentChain();
    orderDivides();
    burstUntilStall();
    playRandomProgram();
    errorCount += dut_i.rob.robChecks.failCount; // bound ROB checker.
    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             testCount, failedTests, checkCount, errorCount);
    if (errorCount == 0)
        $display("ALL CHECKS PASSED");
    else
        $display("CHECKS FAILED");
    $finish;
end

endmodule

// ==== bench/backendAssertions.sv ====
`timescale 1ns/1ps

module backendAssertions
#(
    parameter int robDepth = 8
)
(
    input wire clk,
    input wire rstN,
    input backendPkg::commit_t alloc,
    input backendPkg::commit_t commit,
    input backendPkg::sqN_t headSqN
);

import backendPkg::*;

sqN_t tailSqN; // one past the newest allocation.
sqN_t expectSqN;
sqN_t occupancy;
int failCount = 0;

always_ff @(posedge clk) begin
    if (!rstN) begin
        tailSqN <= '0;
        expectSqN <= '0;
    end else begin
        if (alloc.valid)
            tailSqN <= alloc.sqN + 1'b1;
        if (commit.valid)
            expectSqN <= expectSqN + 1'b1;
    end
end

assign occupancy = tailSqN - headSqN;

commitInOrder: assert property (@(posedge clk) disable iff (!rstN)
    commit.valid |-> commit.sqN == expectSqN)
    else begin
        failCount++;
        $error("commit sequence number is not one more than the previous one");
    end

// the head has already moved on when the commit shows up.
commitNotEmpty: assert property (@(posedge clk) disable iff (!rstN)
    commit.valid |-> $past(occupancy) != 0)
    else begin
        failCount++;
        $error("commit while the reorder buffer was empty");
    end

occupancyBound: assert property (@(posedge clk) disable iff (!rstN)
    occupancy <= robDepth)
    else begin
        failCount++;
        $error("reorder buffer holds more than robDepth entries");
    end

endmodule

bind reorderBuffer backendAssertions #(.robDepth(robDepth)) robChecks
(
    .clk(clk),
    .rstN(rstN),
    .alloc(alloc),
    .commit(commit),
    .headSqN(headSqN)
);

// ==== bench/clockGen.sv ====
`timescale 1ns/1ps

module clockGen
#(
    parameter int periodNs = 100,
    parameter int resetCycles = 4
)
(
    output logic clk,
    output logic rstN
);

initial begin
    clk = 1'b0;
    forever #(periodNs / 2) clk = ~clk;
end

initial begin
    rstN = 1'b0;
    repeat (resetCycles) @(posedge clk);
    #1 rstN = 1'b1; // released just after an edge, like the other stimulus.
end

endmodule

// ==== design/backendCore.sv ====
`timescale 1ns/1ps

module backendCore
#(
    parameter int robDepth = 8,
    parameter int iqDepth = 4
)
(
    input wire clk,
    input wire rstN,

    input backendPkg::instr_t instr,
    output logic stall,
    output backendPkg::commit_t commit
);

import backendPkg::*;

logic iqFull;
sqN_t headSqN;
wbResult_t wb;

sqN_t lookupTag1;
sqN_t lookupTag2;
logic lookupDone1;
logic lookupDone2;
word_t lookupValue1;
word_t lookupValue2;

regIdx_t rfAddr1;
regIdx_t rfAddr2;
word_t rfData1;
word_t rfData2;

iqEntry_t dispIq;
commit_t robAlloc;
issued_t issued;
logic divBusy;

logic rfWe;
regIdx_t rfWaddr;
word_t rfWdata;

dispatch #(.robDepth(robDepth)) disp
(
    .clk(clk),
    .rstN(rstN),

    .instr(instr),
    .stall(stall),
    .iqFull(iqFull),
    .headSqN(headSqN),
    .wb(wb),
    .commit(commit),

    .robLookupTag1(lookupTag1),
    .robLookupTag2(lookupTag2),
    .robLookupDone1(lookupDone1),
    .robLookupDone2(lookupDone2),
    .robLookupValue1(lookupValue1),
    .robLookupValue2(lookupValue2),

    .rfAddr1(rfAddr1),
    .rfAddr2(rfAddr2),
    .rfData1(rfData1),
    .rfData2(rfData2),

    .iqOut(dispIq),
    .robAlloc(robAlloc)
);

issueQueue #(.iqDepth(iqDepth)) iq
(
    .clk(clk),
    .rstN(rstN),

    .in(dispIq),
    .full(iqFull),

    .wb(wb),
    .divBusy(divBusy),

    .out(issued)
);

execPort exec
(
    .clk(clk),
    .rstN(rstN),

    .in(issued),
    .divBusy(divBusy),
    .wb(wb)
);

reorderBuffer #(.robDepth(robDepth)) rob
(
    .clk(clk),
    .rstN(rstN),

    .alloc(robAlloc),
    .wb(wb),

    .lookupTag1(lookupTag1),
    .lookupTag2(lookupTag2),
    .lookupDone1(lookupDone1),
    .lookupDone2(lookupDone2),
    .lookupValue1(lookupValue1),
    .lookupValue2(lookupValue2),

    .headSqN(headSqN),
    .commit(commit),

    .rfWe(rfWe),
    .rfAddr(rfWaddr),
    .rfData(rfWdata)
);

archRegFile rf
(
    .clk(clk),
    .rstN(rstN),

    .raddr1(rfAddr1),
    .raddr2(rfAddr2),
    .rdata1(rfData1),
    .rdata2(rfData2),

    .we(rfWe),
    .waddr(rfWaddr),
    .wdata(rfWdata)
);

endmodule

// ==== design/reorderBuffer.sv ====
`timescale 1ns/1ps

module reorderBuffer
#(
    parameter int robDepth = 8
)
(
    input wire clk,
    input wire rstN,

    input backendPkg::commit_t alloc,
    input backendPkg::wbResult_t wb,

    input backendPkg::sqN_t lookupTag1,
    input backendPkg::sqN_t lookupTag2,
    output logic lookupDone1,
    output logic lookupDone2,
    output backendPkg::word_t lookupValue1,
    output backendPkg::word_t lookupValue2,

    output backendPkg::sqN_t headSqN,
    output backendPkg::commit_t commit,

    output logic rfWe,
    output backendPkg::regIdx_t rfAddr,
    output backendPkg::word_t rfData
);

import backendPkg::*;

localparam int idxW = $clog2(robDepth);
typedef logic [idxW-1:0] robIdx_t;

logic [robDepth-1:0] done;
sqN_t entrySqN[robDepth];
regIdx_t entryRd[robDepth];
word_t entryValue[robDepth];

robIdx_t headIdx;
logic headReady;

function automatic robIdx_t slotOf(sqN_t s);
    return s[idxW-1:0];
endfunction

// the full sequence number is matched, so a stale slot never reads as done.
assign headIdx = slotOf(headSqN);
assign headReady = done[headIdx] && (entrySqN[headIdx] == headSqN);

assign lookupDone1 = done[slotOf(lookupTag1)] && (entrySqN[slotOf(lookupTag1)] == lookupTag1);
assign lookupDone2 = done[slotOf(lookupTag2)] && (entrySqN[slotOf(lookupTag2)] == lookupTag2);
assign lookupValue1 = entryValue[slotOf(lookupTag1)];
assign lookupValue2 = entryValue[slotOf(lookupTag2)];

always_ff @(posedge clk) begin
    if (!rstN) begin
        done <= '0;
        headSqN <= '0;
    end else begin
        if (alloc.valid)
            done[slotOf(alloc.sqN)] <= 1'b0;
        if (wb.valid)
            done[slotOf(wb.sqN)] <= 1'b1;
        if (headReady)
            headSqN <= headSqN + 1'b1;
    end
end

always_ff @(posedge clk) begin
    if (alloc.valid) begin
        entrySqN[slotOf(alloc.sqN)] <= alloc.sqN;
        entryRd[slotOf(alloc.sqN)] <= alloc.rd;
    end
    if (wb.valid)
        entryValue[slotOf(wb.sqN)] <= wb.result;
end

always_ff @(posedge clk) begin
    commit <= '{valid: headReady, sqN: headSqN, rd: entryRd[headIdx],
                value: entryValue[headIdx]};
    if (!rstN)
        commit.valid <= 1'b0;
end

assign rfWe = commit.valid && (commit.rd != '0); // x0 commits are only reported.
assign rfAddr = commit.rd;
assign rfData = commit.value;

endmodule

// ==== design/execPort.sv ====
`timescale 1ns/1ps

module execPort
(
    input wire clk,
    input wire rstN,

    input backendPkg::issued_t in,
    output logic divBusy,
    output backendPkg::wbResult_t wb
);

import backendPkg::*;

wbResult_t aluWb;
wbResult_t divWb;
logic startDiv;

function automatic word_t aluCalc(aluOp_t op, word_t a, word_t b);
    case (op)
        opAdd: return a + b;
        opSub: return a - b;
        opAnd: return a & b;
        opOr: return a | b;
        opXor: return a ^ b;
        opSll: return a << b[4:0];
        opSrl: return a >> b[4:0];
        opSra: return $signed(a) >>> b[4:0];
        opSlt: return {31'b0, $signed(a) < $signed(b)};
        opSltu: return {31'b0, a < b};
        default: return '0;
    endcase
endfunction

assign startDiv = in.valid && isDivOp(in.op);

always_ff @(posedge clk) begin
    aluWb <= '{valid: in.valid && !isDivOp(in.op), sqN: in.sqN,
               result: aluCalc(in.op, in.srcA, in.srcB)};
    if (!rstN)
        aluWb.valid <= 1'b0;
end

divider div
(
    .clk(clk),
    .rstN(rstN),

    .start(startDiv),
    .op(in.op),
    .sqN(in.sqN),
    .dividend(in.srcA),
    .divisor(in.srcB),

    .portFree(!aluWb.valid),
    .busy(divBusy),
    .result(divWb)
);

// the ALU owns the port, a finished divide waits for a free cycle.
assign wb = aluWb.valid ? aluWb : divWb;

endmodule

// ==== design/divider.sv ====
`timescale 1ns/1ps

module divider
(
    input wire clk,
    input wire rstN,

    input wire start,
    input backendPkg::aluOp_t op,
    input backendPkg::sqN_t sqN,
    input backendPkg::word_t dividend,
    input backendPkg::word_t divisor,

    input wire portFree,
    output logic busy,
    output backendPkg::wbResult_t result
);

import backendPkg::*;

logic running;
logic done;
logic [4:0] iter;

word_t quo;
word_t rem;
word_t savedDivisor;
aluOp_t savedOp;
sqN_t savedSqN;

logic [32:0] shifted;
logic [32:0] diff;

assign shifted = {rem, quo[31]};
assign diff = shifted - {1'b0, savedDivisor};

always_ff @(posedge clk) begin
    if (!rstN) begin
        running <= 1'b0;
        done <= 1'b0;
        iter <= '0;
    end else if (start) begin
        running <= 1'b1;
        iter <= '0;
    end else if (running) begin
        iter <= iter + 1'b1;
        if (iter == 5'd31) begin
            running <= 1'b0;
            done <= 1'b1;
        end
    end else if (done && portFree) begin
        done <= 1'b0; // taken by the writeback port.
    end
end

// one restoring step per cycle.
always_ff @(posedge clk) begin
    if (start) begin
        quo <= dividend;
        rem <= '0;
        savedDivisor <= divisor;
        savedOp <= op;
        savedSqN <= sqN;
    end else if (running) begin
        if (!diff[32]) begin
            rem <= diff[31:0];
            quo <= {quo[30:0], 1'b1};
        end else begin
            rem <= shifted[31:0];
            quo <= {quo[30:0], 1'b0};
        end
    end
end

assign busy = start || running || done;
// a divide by zero already leaves all ones in quo and the dividend in rem.
assign result = '{valid: done, sqN: savedSqN,
                  result: (savedOp == opRemu) ? rem : quo};

endmodule

// ==== design/issueQueue.sv ====
`timescale 1ns/1ps

module issueQueue
#(
    parameter int iqDepth = 4
)
(
    input wire clk,
    input wire rstN,

    input backendPkg::iqEntry_t in,
    output logic full,

    input backendPkg::wbResult_t wb,
    input wire divBusy,

    output backendPkg::issued_t out
);

import backendPkg::*;

typedef logic [$clog2(iqDepth)-1:0] slot_t;
typedef logic [$clog2(iqDepth+1)-1:0] count_t;

iqEntry_t entries[iqDepth];
iqEntry_t nextEntries[iqDepth];

logic pickValid;
slot_t pickIdx;
logic freeValid;
slot_t freeIdx;
count_t occupied;

function automatic srcOp_t capture(srcOp_t s, wbResult_t w);
    if (!s.ready && w.valid && w.sqN == s.tag) begin
        s.ready = 1'b1;
        s.value = w.result;
    end
    return s;
endfunction

function automatic logic canIssue(iqEntry_t e, logic blockDiv);
    return e.valid && e.src1.ready && e.src2.ready && !(blockDiv && isDivOp(e.op));
endfunction

// oldest ready entry, and the first empty slot.
always_comb begin
    pickValid = 1'b0;
    pickIdx = '0;
    freeValid = 1'b0;
    freeIdx = '0;
    occupied = '0;
    for (int i = 0; i < iqDepth; i++) begin
        if (canIssue(entries[i], divBusy) &&
            (!pickValid || $signed(entries[i].sqN - entries[pickIdx].sqN) < 0)) begin
            pickValid = 1'b1;
            pickIdx = slot_t'(i);
        end
        if (entries[i].valid)
            occupied = occupied + 1'b1;
        else if (!freeValid) begin
            freeValid = 1'b1;
            freeIdx = slot_t'(i);
        end
    end
end

// leaves room for the entry dispatch may register this cycle.
assign full = (occupied + in.valid) >= iqDepth;

always_comb begin
    for (int i = 0; i < iqDepth; i++) begin
        nextEntries[i] = entries[i];
        nextEntries[i].src1 = capture(entries[i].src1, wb);
        nextEntries[i].src2 = capture(entries[i].src2, wb);
    end
    if (pickValid)
        nextEntries[pickIdx].valid = 1'b0;
    if (in.valid && freeValid) begin
        nextEntries[freeIdx] = in;
        nextEntries[freeIdx].src1 = capture(in.src1, wb); // arrives while in flight.
        nextEntries[freeIdx].src2 = capture(in.src2, wb);
    end
end

always_ff @(posedge clk) begin
    entries <= nextEntries;
    out <= '{valid: pickValid, sqN: entries[pickIdx].sqN, op: entries[pickIdx].op,
             srcA: entries[pickIdx].src1.value, srcB: entries[pickIdx].src2.value};
    if (!rstN) begin
        for (int i = 0; i < iqDepth; i++)
            entries[i].valid <= 1'b0;
        out.valid <= 1'b0;
    end
end

endmodule

// ==== design/dispatch.sv ====
`timescale 1ns/1ps

module dispatch
#(
    parameter int robDepth = 8
)
(
    input wire clk,
    input wire rstN,

    input backendPkg::instr_t instr,
    output logic stall,
    input wire iqFull,
    input backendPkg::sqN_t headSqN,
    input backendPkg::wbResult_t wb,
    input backendPkg::commit_t commit,

    output backendPkg::sqN_t robLookupTag1,
    output backendPkg::sqN_t robLookupTag2,
    input wire robLookupDone1,
    input wire robLookupDone2,
    input backendPkg::word_t robLookupValue1,
    input backendPkg::word_t robLookupValue2,

    output backendPkg::regIdx_t rfAddr1,
    output backendPkg::regIdx_t rfAddr2,
    input backendPkg::word_t rfData1,
    input backendPkg::word_t rfData2,

    output backendPkg::iqEntry_t iqOut,
    output backendPkg::commit_t robAlloc
);

import backendPkg::*;

sqN_t nextSqN;
logic [31:0] pending; // producer table, x0 is never pending.
sqN_t prodSqN[32];

sqN_t inFlight;
logic accept;
srcOp_t src1;
srcOp_t src2;

// file value, finished ROB entry, same-cycle writeback, else wait on the tag.
function automatic srcOp_t resolve(logic isPending, sqN_t tag, word_t rfVal,
                                   logic robDone, word_t robVal, wbResult_t w);
    srcOp_t s;
    s.tag = tag;
    s.ready = 1'b1;
    if (!isPending)
        s.value = rfVal;
    else if (robDone)
        s.value = robVal;
    else if (w.valid && w.sqN == tag)
        s.value = w.result;
    else begin
        s.ready = 1'b0;
        s.value = '0;
    end
    return s;
endfunction

assign inFlight = nextSqN - headSqN; // includes the entry still in iqOut.
assign stall = (inFlight >= robDepth) || iqFull;
assign accept = instr.valid && !stall;

assign rfAddr1 = instr.rs1;
assign rfAddr2 = instr.rs2;
assign robLookupTag1 = prodSqN[instr.rs1];
assign robLookupTag2 = prodSqN[instr.rs2];

always_comb begin
    src1 = resolve(pending[instr.rs1], robLookupTag1, rfData1, robLookupDone1,
                   robLookupValue1, wb);
    src2 = resolve(pending[instr.rs2], robLookupTag2, rfData2, robLookupDone2,
                   robLookupValue2, wb);
    if (instr.useImm)
        src2 = '{ready: 1'b1, tag: '0, value: instr.imm};
end

always_ff @(posedge clk) begin
    if (!rstN) begin
        nextSqN <= '0;
        pending <= '0;
    end else begin
        // a newer producer of the same register keeps it pending.
        if (commit.valid && prodSqN[commit.rd] == commit.sqN)
            pending[commit.rd] <= 1'b0;
        if (accept) begin
            nextSqN <= nextSqN + 1'b1;
            if (instr.rd != '0)
                pending[instr.rd] <= 1'b1;
        end
    end
end

always_ff @(posedge clk) begin
    if (accept)
        prodSqN[instr.rd] <= nextSqN;
end

always_ff @(posedge clk) begin
    iqOut <= '{valid: accept, sqN: nextSqN, op: instr.op, src1: src1, src2: src2};
    robAlloc <= '{valid: accept, sqN: nextSqN, rd: instr.rd, value: '0};
    if (!rstN) begin
        iqOut.valid <= 1'b0;
        robAlloc.valid <= 1'b0;
    end
end

endmodule

// ==== design/archRegFile.sv ====
`timescale 1ns/1ps

module archRegFile
(
    input wire clk,
    input wire rstN,

    input backendPkg::regIdx_t raddr1,
    input backendPkg::regIdx_t raddr2,
    output backendPkg::word_t rdata1,
    output backendPkg::word_t rdata2,

    input wire we,
    input backendPkg::regIdx_t waddr,
    input backendPkg::word_t wdata
);

import backendPkg::*;

word_t regs[31:1]; // x0 has no storage.

always_ff @(posedge clk) begin
    if (!rstN) begin
        for (int i = 1; i < 32; i++)
            regs[i] <= '0;
    end else if (we && waddr != '0) begin
        regs[waddr] <= wdata;
    end
end

assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== design/backendPkg.sv ====
package backendPkg;

typedef logic [31:0] word_t;
typedef logic [4:0] regIdx_t;
typedef logic [5:0] sqN_t; // wraps, age is the signed difference.
typedef logic [3:0] aluOp_t;

localparam aluOp_t opAdd = 4'd0;
localparam aluOp_t opSub = 4'd1;
localparam aluOp_t opAnd = 4'd2;
localparam aluOp_t opOr = 4'd3;
localparam aluOp_t opXor = 4'd4;
localparam aluOp_t opSll = 4'd5;
localparam aluOp_t opSrl = 4'd6;
localparam aluOp_t opSra = 4'd7;
localparam aluOp_t opSlt = 4'd8;
localparam aluOp_t opSltu = 4'd9;
localparam aluOp_t opDivu = 4'd10;
localparam aluOp_t opRemu = 4'd11;

function automatic logic isDivOp(aluOp_t op);
    return (op == opDivu) || (op == opRemu);
endfunction

typedef struct packed {
    logic valid;
    aluOp_t op;
    regIdx_t rd;
    regIdx_t rs1;
    regIdx_t rs2;
    word_t imm;
    logic useImm; // imm takes the place of rs2.
} instr_t;

// one source operand, either a value or a wait on the producer's tag.
typedef struct packed {
    logic ready;
    sqN_t tag;
    word_t value;
} srcOp_t;

typedef struct packed {
    logic valid;
    sqN_t sqN;
    aluOp_t op;
    srcOp_t src1;
    srcOp_t src2;
} iqEntry_t;

typedef struct packed {
    logic valid;
    sqN_t sqN;
    aluOp_t op;
    word_t srcA;
    word_t srcB;
} issued_t;

typedef struct packed {
    logic valid;
    sqN_t sqN;
    word_t result;
} wbResult_t;

typedef struct packed {
    logic valid;
    sqN_t sqN;
    regIdx_t rd;
    word_t value;
} commit_t;

endpackage
